// ==== hdl/bridge_pkg.sv ====
// bridge package
// frame constants, command codes and parser state encodings
// shared by the parser, the transfer engine and the byte stores

`default_nettype none

package bridge_pkg;

    ////////////////////////////////////////////////////////////
    // widths and depth
    ////////////////////////////////////////////////////////////

    // one byte per beat
    localparam int DATA_W = 8;
    // store address, depth follows from it
    localparam int ADDR_W = 8;
    localparam int MEM_DEPTH = 1 << ADDR_W;

    ////////////////////////////////////////////////////////////
    // frame constants
    ////////////////////////////////////////////////////////////

    // frame start marker
    localparam logic [DATA_W-1:0] HEAD_BYTE = 8'hAA;
    // erased flash byte
    localparam logic [DATA_W-1:0] ERASE_VALUE = 8'hFF;

    // command byte codes, one bit each
    typedef enum logic [DATA_W-1:0] {
        CMD_READ_RAM    = 8'h01,
        CMD_WRITE_RAM   = 8'h02,
        CMD_WRITE_FLASH = 8'h04,
        CMD_READ_FLASH  = 8'h08,
        CMD_ERASE_FLASH = 8'h10
    } cmd_e;

    // parser walk, one-hot
    typedef enum logic [6:0] {
        S_WAIT_HEAD    = 7'b000_0001,
        S_WAIT_LENGTH  = 7'b000_0010,
        S_WAIT_COMMAND = 7'b000_0100,
        S_WAIT_ADDR    = 7'b000_1000,
        S_REQUEST      = 7'b001_0000,
        S_PAYLOAD      = 7'b010_0000,
        S_RELEASE      = 7'b100_0000
    } parser_state_e;

endpackage

`default_nettype wire

// ==== hdl/byte_store.sv ====
// byte store
// 256 bytes, synchronous write, registered one-cycle read;
// program-only mode clears bits unless erase forces the byte

`default_nettype none

module byte_store #(
    parameter bit PROGRAM_ONLY = 1'b0
) (
    input  wire                              rx_flag,
    input  wire                              we,
    input  wire                              erase,
    input  wire  [bridge_pkg::ADDR_W-1:0]    waddr,
    input  wire  [bridge_pkg::DATA_W-1:0]    wdata,
    input  wire  [bridge_pkg::ADDR_W-1:0]    raddr,
    output logic [bridge_pkg::DATA_W-1:0]    rdata
);

    logic [bridge_pkg::DATA_W-1:0] mem [bridge_pkg::MEM_DEPTH];

    ////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////

    always_ff @(posedge rx_flag) begin
        if (we) begin
            // flash program can only pull bits low
            if (PROGRAM_ONLY && !erase) begin
                mem[waddr] <= mem[waddr] & wdata;
            end else begin
                mem[waddr] <= wdata;
            end
        end
    end

    // read port, old data on a same-address collision
    always_ff @(posedge rx_flag) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

// ==== hdl/frame_parser.sv ====
// frame parser
// hunts for the head byte, captures length, command and address,
// then hands the command to the engine over a four-phase req/ack

`default_nettype none

module frame_parser (
    input  wire              rx_flag,
    input  wire              transFinish,
    input  wire              in_valid,
    input  wire  [7:0]       in_data,
    output logic             in_ready,
    output logic             cmd_req,
    input  wire              cmd_ack,
    output bridge_pkg::cmd_e cmd_code,
    output logic [7:0]       cmd_len,
    output logic [7:0]       cmd_addr,
    output logic             pay_valid,
    output logic [7:0]       pay_data,
    input  wire              pay_ready,
    output logic             frame_done,
    output logic             frame_error
);

    bridge_pkg::parser_state_e state;
    logic accept;
    logic known_cmd;
    logic is_write;

    ////////////////////////////////////////////////////////////
    // combinational side
    ////////////////////////////////////////////////////////////

    // header states always take a byte, payload follows the engine
    always_comb begin
        case (state)
            bridge_pkg::S_WAIT_HEAD,
            bridge_pkg::S_WAIT_LENGTH,
            bridge_pkg::S_WAIT_COMMAND,
            bridge_pkg::S_WAIT_ADDR: in_ready = 1'b1;
            bridge_pkg::S_PAYLOAD:   in_ready = pay_ready;
            default:                 in_ready = 1'b0;
        endcase
    end

    assign accept = in_valid && in_ready;

    // payload goes straight through to the engine
    assign pay_valid = in_valid && (state == bridge_pkg::S_PAYLOAD);
    assign pay_data  = in_data;

    // the only command decode in the design
    always_comb begin
        case (in_data)
            bridge_pkg::CMD_READ_RAM,
            bridge_pkg::CMD_WRITE_RAM,
            bridge_pkg::CMD_WRITE_FLASH,
            bridge_pkg::CMD_READ_FLASH,
            bridge_pkg::CMD_ERASE_FLASH: known_cmd = 1'b1;
            default:                     known_cmd = 1'b0;
        endcase
    end

    // writes carry payload
    assign is_write = (cmd_code == bridge_pkg::CMD_WRITE_RAM) ||
                      (cmd_code == bridge_pkg::CMD_WRITE_FLASH);

    ////////////////////////////////////////////////////////////
    // state walk
    ////////////////////////////////////////////////////////////

    always_ff @(posedge rx_flag or posedge transFinish) begin
        if (transFinish) begin
            state       <= bridge_pkg::S_WAIT_HEAD;
            cmd_req     <= 1'b0;
            cmd_code    <= bridge_pkg::CMD_READ_RAM;
            cmd_len     <= 8'd0;
            cmd_addr    <= 8'd0;
            frame_done  <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            // status flags are single-cycle pulses
            frame_done  <= 1'b0;
            frame_error <= 1'b0;
            case (state)
                bridge_pkg::S_WAIT_HEAD: begin
                    // anything but the marker is dropped
                    if (accept && in_data == bridge_pkg::HEAD_BYTE) begin
                        state <= bridge_pkg::S_WAIT_LENGTH;
                    end
                end
                bridge_pkg::S_WAIT_LENGTH: begin
                    if (accept) begin
                        cmd_len <= in_data;
                        state   <= bridge_pkg::S_WAIT_COMMAND;
                    end
                end
                bridge_pkg::S_WAIT_COMMAND: begin
                    if (accept && known_cmd) begin
                        cmd_code <= bridge_pkg::cmd_e'(in_data);
                        state    <= bridge_pkg::S_WAIT_ADDR;
                    end else if (accept) begin
                        // unknown code, back to the hunt
                        frame_error <= 1'b1;
                        state       <= bridge_pkg::S_WAIT_HEAD;
                    end
                end
                bridge_pkg::S_WAIT_ADDR: begin
                    if (accept) begin
                        cmd_addr <= in_data;
                        state    <= bridge_pkg::S_REQUEST;
                    end
                end
                bridge_pkg::S_REQUEST: begin
                    // previous ack must be gone first
                    if (!cmd_ack) begin
                        cmd_req <= 1'b1;
                        state   <= is_write ? bridge_pkg::S_PAYLOAD : bridge_pkg::S_RELEASE;
                    end
                end
                bridge_pkg::S_PAYLOAD: begin
                    // engine acks after the last payload byte
                    if (cmd_ack) begin
                        cmd_req <= 1'b0;
                        state   <= bridge_pkg::S_RELEASE;
                    end
                end
                bridge_pkg::S_RELEASE: begin
                    if (cmd_req) begin
                        if (cmd_ack) begin
                            cmd_req <= 1'b0;
                        end
                    end else if (!cmd_ack) begin
                        // handshake closed
                        frame_done <= 1'b1;
                        state      <= bridge_pkg::S_WAIT_HEAD;
                    end
                end
                default: state <= bridge_pkg::S_WAIT_HEAD;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // handshake checks
    ////////////////////////////////////////////////////////////

    // engine relies on a steady command during the request
    a_code_stable: assert property (@(posedge rx_flag) disable iff (transFinish)
        cmd_req && $past(cmd_req) |-> $stable(cmd_code));

    // four-phase rule, a new request waits for the old ack to fall
    a_req_after_ack: assert property (@(posedge rx_flag) disable iff (transFinish)
        $rose(cmd_req) |-> !$past(cmd_ack));

endmodule

`default_nettype wire

// ==== hdl/transfer_engine.sv ====
// transfer engine
// runs one command against the RAM or flash store, streams payload in,
// read data out, and sweeps the flash on erase

`default_nettype none

module transfer_engine (
    input  wire                   rx_flag,
    input  wire                   transFinish,
    input  wire                   cmd_req,
    output logic                  cmd_ack,
    input  wire bridge_pkg::cmd_e cmd_code,
    input  wire  [7:0]            cmd_len,
    input  wire  [7:0]            cmd_addr,
    input  wire                   pay_valid,
    input  wire  [7:0]            pay_data,
    output logic                  pay_ready,
    output logic                  out_valid,
    output logic [7:0]            out_data,
    input  wire                   out_ready,
    output logic                  ram_we,
    output logic [7:0]            ram_waddr,
    output logic [7:0]            ram_wdata,
    output logic [7:0]            ram_raddr,
    input  wire  [7:0]            ram_rdata,
    output logic                  flash_we,
    output logic                  flash_erase,
    output logic [7:0]            flash_waddr,
    output logic [7:0]            flash_wdata,
    output logic [7:0]            flash_raddr,
    input  wire  [7:0]            flash_rdata
);

    logic       busy;
    logic       rd_pend;
    logic [7:0] remain;
    logic [7:0] ptr;
    logic       is_write;
    logic       is_read;
    logic       is_erase;
    logic       start;
    logic       pay_fire;
    logic       rd_issue;
    logic       rd_last;

    ////////////////////////////////////////////////////////////
    // command class and strobes
    ////////////////////////////////////////////////////////////

    assign is_write = (cmd_code == bridge_pkg::CMD_WRITE_RAM) ||
                      (cmd_code == bridge_pkg::CMD_WRITE_FLASH);
    assign is_read  = (cmd_code == bridge_pkg::CMD_READ_RAM) ||
                      (cmd_code == bridge_pkg::CMD_READ_FLASH);
    assign is_erase = (cmd_code == bridge_pkg::CMD_ERASE_FLASH);

    // new request, old ack fully released
    assign start = cmd_req && !busy && !cmd_ack;

    assign pay_ready = busy && is_write && (remain != 8'd0);
    assign pay_fire  = pay_valid && pay_ready;

    // one read in flight, only into an empty output slot
    assign rd_issue = busy && is_read && (remain != 8'd0) && !rd_pend && !out_valid;
    // last byte taken downstream
    assign rd_last  = busy && is_read && (remain == 8'd0) && !rd_pend && out_valid && out_ready;

    ////////////////////////////////////////////////////////////
    // store steering
    ////////////////////////////////////////////////////////////

    assign ram_we    = pay_fire && (cmd_code == bridge_pkg::CMD_WRITE_RAM);
    assign ram_waddr = ptr;
    assign ram_wdata = pay_data;
    assign ram_raddr = ptr;

    // erase forces the byte past the program-only rule
    assign flash_erase = busy && is_erase;
    assign flash_we    = flash_erase || (pay_fire && (cmd_code == bridge_pkg::CMD_WRITE_FLASH));
    assign flash_waddr = ptr;
    assign flash_wdata = flash_erase ? bridge_pkg::ERASE_VALUE : pay_data;
    assign flash_raddr = ptr;

    ////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge rx_flag or posedge transFinish) begin
        if (transFinish) begin
            busy      <= 1'b0;
            rd_pend   <= 1'b0;
            remain    <= 8'd0;
            ptr       <= 8'd0;
            cmd_ack   <= 1'b0;
            out_valid <= 1'b0;
            out_data  <= 8'd0;
        end else begin
            // release phase
            if (cmd_ack && !cmd_req) begin
                cmd_ack <= 1'b0;
            end
            if (start) begin
                ptr    <= is_erase ? 8'd0 : cmd_addr;
                remain <= cmd_len;
                // empty transfer acks at once
                if (cmd_len == 8'd0 && !is_erase) begin
                    cmd_ack <= 1'b1;
                end else begin
                    busy <= 1'b1;
                end
            end else if (busy && is_erase) begin
                // full sweep, address wraps back to zero
                ptr <= ptr + 8'd1;
                if (ptr == 8'hFF) begin
                    busy    <= 1'b0;
                    cmd_ack <= 1'b1;
                end
            end else if (busy && is_write) begin
                if (pay_fire) begin
                    ptr    <= ptr + 8'd1;
                    remain <= remain - 8'd1;
                    if (remain == 8'd1) begin
                        busy    <= 1'b0;
                        cmd_ack <= 1'b1;
                    end
                end
            end else if (busy) begin
                // read, ptr already points at the next byte
                if (rd_issue) begin
                    rd_pend <= 1'b1;
                    ptr     <= ptr + 8'd1;
                    remain  <= remain - 8'd1;
                end
                if (rd_pend) begin
                    rd_pend   <= 1'b0;
                    out_valid <= 1'b1;
                    out_data  <= (cmd_code == bridge_pkg::CMD_READ_RAM) ? ram_rdata : flash_rdata;
                end else if (out_valid && out_ready) begin
                    out_valid <= 1'b0;
                end
                if (rd_last) begin
                    busy    <= 1'b0;
                    cmd_ack <= 1'b1;
                end
            end
        end
    end

    // held byte must survive back-pressure
    a_out_hold: assert property (@(posedge rx_flag) disable iff (transFinish)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

// ==== hdl/cmd_bridge_top.sv ====
// command bridge top
// byte-stream frame parser and transfer engine over a RAM
// and an emulated flash store

`default_nettype none

module cmd_bridge_top (
    input  wire        rx_flag,
    input  wire        transFinish,
    input  wire        in_valid,
    input  wire  [7:0] in_data,
    output wire        in_ready,
    output wire        out_valid,
    output wire  [7:0] out_data,
    input  wire        out_ready,
    output wire        frame_done,
    output wire        frame_error
);

    ////////////////////////////////////////////////////////////
    // internal nets
    ////////////////////////////////////////////////////////////

    // command handshake
    wire                   cmd_req;
    wire                   cmd_ack;
    wire bridge_pkg::cmd_e cmd_code;
    wire [7:0]             cmd_len;
    wire [7:0]             cmd_addr;

    // payload path
    wire                   pay_valid;
    wire [7:0]             pay_data;
    wire                   pay_ready;

    // store ports
    wire                   ram_we;
    wire [7:0]             ram_waddr;
    wire [7:0]             ram_wdata;
    wire [7:0]             ram_raddr;
    wire [7:0]             ram_rdata;
    wire                   flash_we;
    wire                   flash_erase;
    wire [7:0]             flash_waddr;
    wire [7:0]             flash_wdata;
    wire [7:0]             flash_raddr;
    wire [7:0]             flash_rdata;

    ////////////////////////////////////////////////////////////
    // blocks
    ////////////////////////////////////////////////////////////

    frame_parser parser_i (
        .rx_flag(rx_flag), .transFinish(transFinish),
        .in_valid(in_valid), .in_data(in_data), .in_ready(in_ready),
        .cmd_req(cmd_req), .cmd_ack(cmd_ack), .cmd_code(cmd_code),
        .cmd_len(cmd_len), .cmd_addr(cmd_addr),
        .pay_valid(pay_valid), .pay_data(pay_data), .pay_ready(pay_ready),
        .frame_done(frame_done), .frame_error(frame_error)
    );

    transfer_engine engine_i (
        .rx_flag(rx_flag), .transFinish(transFinish),
        .cmd_req(cmd_req), .cmd_ack(cmd_ack), .cmd_code(cmd_code),
        .cmd_len(cmd_len), .cmd_addr(cmd_addr),
        .pay_valid(pay_valid), .pay_data(pay_data), .pay_ready(pay_ready),
        .out_valid(out_valid), .out_data(out_data), .out_ready(out_ready),
        .ram_we(ram_we), .ram_waddr(ram_waddr), .ram_wdata(ram_wdata),
        .ram_raddr(ram_raddr), .ram_rdata(ram_rdata),
        .flash_we(flash_we), .flash_erase(flash_erase),
        .flash_waddr(flash_waddr), .flash_wdata(flash_wdata),
        .flash_raddr(flash_raddr), .flash_rdata(flash_rdata)
    );

    // plain RAM, never erased
    byte_store #(.PROGRAM_ONLY(1'b0)) ram_store_i (
        .rx_flag(rx_flag), .we(ram_we), .erase(1'b0),
        .waddr(ram_waddr), .wdata(ram_wdata),
        .raddr(ram_raddr), .rdata(ram_rdata)
    );

    // flash emulation, AND on program
    byte_store #(.PROGRAM_ONLY(1'b1)) flash_store_i (
        .rx_flag(rx_flag), .we(flash_we), .erase(flash_erase),
        .waddr(flash_waddr), .wdata(flash_wdata),
        .raddr(flash_raddr), .rdata(flash_rdata)
    );

endmodule

`default_nettype wire

// ==== tb/tb_checker.sv ====
// result checker for the command bridge
// compares read bytes against the expected queue, counts status pulses
// and prints one line per finished test

`default_nettype none

module tb_checker (
    input wire       rx_flag,
    input wire       transFinish,
    input wire       out_valid,
    input wire [7:0] out_data,
    input wire       out_ready,
    input wire       frame_done,
    input wire       frame_error
);

    // bytes the model expects on out_data, oldest first
    logic [7:0] exp_q[$];
    int         done_seen;
    int         error_seen;
    int         errors;
    int         errors_at_start;
    int         tests_run;
    int         tests_failed;

    initial begin
        done_seen       = 0;
        error_seen      = 0;
        errors          = 0;
        errors_at_start = 0;
        tests_run       = 0;
        tests_failed    = 0;
    end

    ////////////////////////////////////////////////////////////
    // value and timeout reports
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting: %s", what);
        errors++;
    endtask

    task automatic push_expected(input logic [7:0] b);
        exp_q.push_back(b);
    endtask

    ////////////////////////////////////////////////////////////
    // test bracketing
    ////////////////////////////////////////////////////////////

    task automatic begin_test();
        done_seen       = 0;
        error_seen      = 0;
        errors_at_start = errors;
    endtask

    task automatic end_test(input string name, input int exp_done, input int exp_err);
        // leftover bytes mean the read stream fell short
        if (exp_q.size() != 0) begin
            $display("test %s: %0d read bytes never came out", name, exp_q.size());
            errors++;
            exp_q.delete();
        end
        check_value("frame_done count", 8'(done_seen), 8'(exp_done));
        check_value("frame_error count", 8'(error_seen), 8'(exp_err));
        tests_run++;
        if (errors != errors_at_start) begin
            tests_failed++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: passed", name);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // port watch
    ////////////////////////////////////////////////////////////

    // sampled on the edge, inputs settle a unit later
    always @(posedge rx_flag) begin
        if (!transFinish) begin
            if (frame_done) begin
                done_seen++;
            end
            if (frame_error) begin
                error_seen++;
            end
            // a byte leaves on valid and ready together
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("read byte %h came out with nothing expected", out_data);
                    errors++;
                end else begin
                    check_value("out_data", out_data, exp_q.pop_front());
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_cmd_bridge.sv ====
// command bridge testbench
// random frames into the bridge, reference models of the RAM and flash,
// expected read bytes handed to the checker

`default_nettype none

module tb_cmd_bridge;

    // cycle limits for the wait loops
    localparam int BYTE_LIMIT  = 200;
    localparam int FRAME_LIMIT = 4000;

    logic       rx_flag;
    logic       transFinish;
    logic       in_valid;
    logic [7:0] in_data;
    logic       out_ready;
    wire        in_ready;
    wire        out_valid;
    wire  [7:0] out_data;
    wire        frame_done;
    wire        frame_error;

    integer     seed;
    integer     ready_seed;
    bit         gaps_on;
    logic       next_ready;
    logic [7:0] ram_model   [256];
    logic [7:0] flash_model [256];
    logic [7:0] last_addr;
    logic [7:0] last_len;

    cmd_bridge_top dut_i (
        .rx_flag(rx_flag), .transFinish(transFinish),
        .in_valid(in_valid), .in_data(in_data), .in_ready(in_ready),
        .out_valid(out_valid), .out_data(out_data), .out_ready(out_ready),
        .frame_done(frame_done), .frame_error(frame_error)
    );

    tb_checker chk_i (
        .rx_flag(rx_flag), .transFinish(transFinish),
        .out_valid(out_valid), .out_data(out_data), .out_ready(out_ready),
        .frame_done(frame_done), .frame_error(frame_error)
    );

    // 8 unit period
    always #4 rx_flag = ~rx_flag;

    // downstream back-pressure is random only when gaps are on
    always @(posedge rx_flag) begin
        next_ready = gaps_on ? (($random(ready_seed) & 3) != 0) : 1'b1;
        #1;
        out_ready = next_ready;
    end

    ////////////////////////////////////////////////////////////
    // random helpers and command rules
    ////////////////////////////////////////////////////////////

    function automatic logic [7:0] next_rand();
        return 8'($random(seed));
    endfunction

    // lengths 1 to 16
    function automatic logic [7:0] rand_len();
        return (next_rand() & 8'h0F) + 8'd1;
    endfunction

    function automatic bit is_valid_cmd(input logic [7:0] c);
        return (c == 8'h01) || (c == 8'h02) || (c == 8'h04) || (c == 8'h08) || (c == 8'h10);
    endfunction

    ////////////////////////////////////////////////////////////
    // byte and frame drivers entered and left 1 unit past the edge
    ////////////////////////////////////////////////////////////

    task automatic send_byte(input logic [7:0] b);
        int gap;
        int t;
        gap = gaps_on ? int'(next_rand() & 8'h03) : 0;
        repeat (gap) begin
            @(posedge rx_flag);
            #1;
        end
        in_valid = 1'b1;
        in_data  = b;
        t = 0;
        @(posedge rx_flag);
        while (!in_ready && t < BYTE_LIMIT) begin
            @(posedge rx_flag);
            t++;
        end
        if (!in_ready) begin
            chk_i.report_timeout("input byte was never accepted");
        end
        #1;
        in_valid = 1'b0;
    endtask

    // header bytes go head, length, command then address
    task automatic send_header(input logic [7:0] len, input logic [7:0] cmd,
                               input logic [7:0] addr);
        send_byte(bridge_pkg::HEAD_BYTE);
        send_byte(len);
        send_byte(cmd);
        send_byte(addr);
    endtask

    // which = 1 waits for frame_error, else frame_done
    task automatic wait_flag(input bit which);
        int t;
        bit hit;
        t   = 0;
        hit = 1'b0;
        while (!hit && t < FRAME_LIMIT) begin
            @(posedge rx_flag);
            hit = which ? frame_error : frame_done;
            t++;
        end
        if (!hit) begin
            chk_i.report_timeout(which ? "frame_error pulse" : "frame_done pulse");
        end
        #1;
    endtask

    // ram takes the byte, flash keeps only cleared bits
    task automatic write_frame(input logic [7:0] cmd, input logic [7:0] addr,
                               input logic [7:0] len);
        logic [7:0] a;
        logic [7:0] b;
        int         k;
        send_header(len, cmd, addr);
        a = addr;
        for (k = 0; k < len; k++) begin
            b = next_rand();
            if (cmd == bridge_pkg::CMD_WRITE_RAM) begin
                ram_model[a] = b;
            end else begin
                flash_model[a] = flash_model[a] & b;
            end
            send_byte(b);
            a = a + 8'd1;
        end
        wait_flag(1'b0);
    endtask

    task automatic read_frame(input logic [7:0] cmd, input logic [7:0] addr,
                              input logic [7:0] len);
        logic [7:0] a;
        int         k;
        a = addr;
        // address wraps modulo 256
        for (k = 0; k < len; k++) begin
            chk_i.push_expected(cmd == bridge_pkg::CMD_READ_RAM ? ram_model[a] : flash_model[a]);
            a = a + 8'd1;
        end
        send_header(len, cmd, addr);
        wait_flag(1'b0);
    endtask

    task automatic erase_flash();
        int k;
        for (k = 0; k < 256; k++) begin
            flash_model[k] = bridge_pkg::ERASE_VALUE;
        end
        send_header(8'd0, bridge_pkg::CMD_ERASE_FLASH, 8'd0);
        wait_flag(1'b0);
    endtask

    // noise on the line that never hits the head byte
    task automatic send_garbage(input int n);
        logic [7:0] b;
        int         k;
        for (k = 0; k < n; k++) begin
            b = next_rand();
            if (b == bridge_pkg::HEAD_BYTE) begin
                b = 8'h55;
            end
            send_byte(b);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int         i;
        int         t;
        logic [7:0] addr;
        logic [7:0] len;
        logic [7:0] b;
        seed        = 11065;
        ready_seed  = 11065;
        rx_flag     = 1'b0;
        transFinish = 1'b1;
        in_valid    = 1'b0;
        in_data     = 8'd0;
        out_ready   = 1'b1;
        gaps_on     = 1'b0;
        repeat (8) @(posedge rx_flag);
        #1;
        transFinish = 1'b0;

        // ram write then read with the first frame forced across the wrap
        chk_i.begin_test();
        for (i = 0; i < 6; i++) begin
            addr = (i == 0) ? 8'hF8 : next_rand();
            len  = (i == 0) ? 8'd16 : rand_len();
            write_frame(bridge_pkg::CMD_WRITE_RAM, addr, len);
            read_frame(bridge_pkg::CMD_READ_RAM, addr, len);
            last_addr = addr;
            last_len  = len;
        end
        chk_i.end_test("ram_write_read", 12, 0);

        // flash programs twice over the same bytes
        chk_i.begin_test();
        erase_flash();
        for (i = 0; i < 4; i++) begin
            addr = next_rand();
            len  = rand_len();
            write_frame(bridge_pkg::CMD_WRITE_FLASH, addr, len);
            write_frame(bridge_pkg::CMD_WRITE_FLASH, addr, len);
            read_frame(bridge_pkg::CMD_READ_FLASH, addr, len);
        end
        chk_i.end_test("flash_program_only", 13, 0);

        // erase then a long read with ram left alone
        chk_i.begin_test();
        erase_flash();
        read_frame(bridge_pkg::CMD_READ_FLASH, next_rand(), 8'd255);
        read_frame(bridge_pkg::CMD_READ_FLASH, next_rand(), rand_len());
        read_frame(bridge_pkg::CMD_READ_RAM, last_addr, last_len);
        chk_i.end_test("flash_erase", 4, 0);

        // garbage, bad command, then a good frame pair
        chk_i.begin_test();
        send_garbage(5);
        b = next_rand();
        if (is_valid_cmd(b)) begin
            b = 8'h03;
        end
        // bad command ends the frame before any address byte
        send_byte(bridge_pkg::HEAD_BYTE);
        send_byte(rand_len());
        send_byte(b);
        wait_flag(1'b1);
        send_garbage(3);
        addr = next_rand();
        len  = rand_len();
        write_frame(bridge_pkg::CMD_WRITE_RAM, addr, len);
        read_frame(bridge_pkg::CMD_READ_RAM, addr, len);
        chk_i.end_test("framing", 2, 1);

        // gaps on both sides of the bridge
        chk_i.begin_test();
        gaps_on = 1'b1;
        for (i = 0; i < 6; i++) begin
            addr = next_rand();
            len  = rand_len();
            write_frame(bridge_pkg::CMD_WRITE_RAM, addr, len);
            read_frame(bridge_pkg::CMD_READ_RAM, addr, len);
        end
        gaps_on = 1'b0;
        chk_i.end_test("back_pressure", 12, 0);

        // reset while the first read byte sits on the output
        chk_i.begin_test();
        addr = next_rand();
        send_header(8'd8, bridge_pkg::CMD_READ_RAM, addr);
        t = 0;
        while (!out_valid && t < BYTE_LIMIT) begin
            @(posedge rx_flag);
            #1;
            t++;
        end
        if (!out_valid) begin
            chk_i.report_timeout("first read byte before reset");
        end
        transFinish = 1'b1;
        @(posedge rx_flag);
        chk_i.check_value("in_ready", {7'd0, in_ready}, 8'h01);
        chk_i.check_value("out_valid", {7'd0, out_valid}, 8'h00);
        chk_i.check_value("frame_done", {7'd0, frame_done}, 8'h00);
        chk_i.check_value("frame_error", {7'd0, frame_error}, 8'h00);
        repeat (3) @(posedge rx_flag);
        #1;
        transFinish = 1'b0;
        addr = next_rand();
        len  = rand_len();
        write_frame(bridge_pkg::CMD_WRITE_RAM, addr, len);
        read_frame(bridge_pkg::CMD_READ_RAM, addr, len);
        chk_i.end_test("reset", 2, 0);

        $display("tests %0d, failed %0d, errors %0d",
                 chk_i.tests_run, chk_i.tests_failed, chk_i.errors);
        if (chk_i.errors == 0 && chk_i.tests_failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
hdl/bridge_pkg.sv
hdl/byte_store.sv
hdl/frame_parser.sv
hdl/transfer_engine.sv
hdl/cmd_bridge_top.sv
tb/tb_checker.sv
tb/tb_cmd_bridge.sv

// ==== Bender.yml ====
package:
  name: cmd_bridge

sources:
  - hdl/bridge_pkg.sv
  - hdl/byte_store.sv
  - hdl/frame_parser.sv
  - hdl/transfer_engine.sv
  - hdl/cmd_bridge_top.sv
  - target: simulation
    files:
      - tb/tb_checker.sv
      - tb/tb_cmd_bridge.sv
